//--- build.f
rtl/scope_pkg.sv
rtl/scope_capture.sv
rtl/scope_bus_port.sv
rtl/scope_top.sv
verif/scope_properties.sv
verif/scope_tb.sv

//--- run.sh
#!/bin/sh

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module scope_tb \
	-f build.f --Mdir "$build_dir" -o scope_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$build_dir/scope_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$log"; then
	echo "Failures found in $log"
	exit 1
fi

echo "No failures found in $log"
exit 0

//--- verif/scope_tb.sv
module scope_tb;
	import scope_pkg::*;

	localparam int size = 16;
	localparam int max_cycles = 2000;  // Generous bound over the total length of all tests.

	logic clk;
	logic reset;
	logic start_core;
	logic start_mem;
	probe_core_t core_probe;
	probe_mem_t mem_probe;
	scope_cmd_t bus_in;
	logic bus_write;
	logic bus_read;
	logic [scope_busw-1:0] bus_out;

	integer seed;
	int errors;
	int cycles = 0;
	probe_core_t core_stim [32];
	probe_mem_t mem_stim [32];

	scope_top #(
		.SIZE(size)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.start_core(start_core),
		.start_mem(start_mem),
		.core_probe(core_probe),
		.mem_probe(mem_probe),
		.bus_in(bus_in),
		.bus_write(bus_write),
		.bus_read(bus_read),
		.bus_out(bus_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles, the tests did not finish", max_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// One host write that the port registers on the second edge.
	task automatic send_cmd(input scope_cmd_e code, input logic chan, input logic [31:0] arg);
		scope_cmd_t cmd;
		cmd = '0;
		cmd.arg = 59'(arg);
		cmd.chan = chan;
		cmd.code = code;
		@(posedge clk);
		bus_in <= cmd;
		bus_write <= 1'b1;
		@(posedge clk);
		bus_write <= 1'b0;
	endtask

	task automatic get_value(input scope_cmd_e code, input logic chan,
		output logic [63:0] value);
		send_cmd(code, chan, 32'd0);
		@(negedge clk);
		value = bus_out;
	endtask

	task automatic pulse_read();
		@(posedge clk);
		bus_read <= 1'b1;
		@(posedge clk);
		bus_read <= 1'b0;
	endtask

	task automatic read_word(output logic [63:0] value);
		@(negedge clk);
		value = bus_out;  // Sampled before the strobe moves the pointer.
		pulse_read();
	endtask

	task automatic wait_valid(input logic chan);
		logic [63:0] value;
		int polls;
		get_value(cmd_get_valid, chan, value);
		polls = 0;
		while (value[0] !== 1'b1 && polls < 100) begin
			@(negedge clk);
			value = bus_out;
			polls++;
		end
		assert (value[0] === 1'b1) else begin
			errors++;
			$display("Capture on channel %0d never reported valid data", chan);
		end
	endtask

	function automatic probe_core_t random_core(input logic [31:0] pc);
		probe_core_t p;
		p.pc = pc;
		p.warp_id = 4'($random(seed));
		p.stall = 1'($random(seed));
		p.issue = 1'($random(seed));
		p.stage = 2'($random(seed));
		return p;
	endfunction

	function automatic probe_mem_t random_mem();
		probe_mem_t p;
		p.addr = $random(seed);
		p.wdata = {$random(seed), $random(seed)};
		p.rw = 1'($random(seed));
		p.req_valid = 1'($random(seed));
		p.tag = 2'($random(seed));
		return p;
	endfunction

	task automatic fill_stimulus(input int len);
		int i;
		for (i = 0; i < len; i++) begin
			core_stim[i] = random_core(32'h1000 + 32'(i) * 32'd4);  // Ramp on pc.
			mem_stim[i] = random_mem();
		end
	endtask

	// Start goes out with entry 0, so entry k is on the probe at the k-th edge after start.
	task automatic drive_capture(input logic on_core, input logic on_mem, input int len);
		int i;
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			start_core <= on_core && (i == 0);
			start_mem <= on_mem && (i == 0);
			core_probe <= core_stim[i];
			mem_probe <= mem_stim[i];
		end
	endtask

	task automatic read_core_sample(input probe_core_t expected, input int index);
		logic [63:0] word;
		read_word(word);
		check_value($sformatf("core bus_out sample %0d", index), 128'(expected), 128'(word));
	endtask

	// Memory samples are two words, low first, with zeros above bit 99.
	task automatic read_mem_sample(input probe_mem_t expected, input int index);
		logic [127:0] line;
		logic [63:0] word;
		line = 128'(expected);
		read_word(word);
		check_value($sformatf("mem bus_out sample %0d low", index), 128'(line[63:0]), 128'(word));
		read_word(word);
		check_value($sformatf("mem bus_out sample %0d high", index), 128'(line[127:64]),
			128'(word));
	endtask

	task automatic check_reset_values();
		logic [63:0] value;
		get_value(cmd_get_width, 1'b0, value);
		check_value("core width", 128'(40), 128'(value));
		get_value(cmd_get_depth, 1'b0, value);
		check_value("core depth", 128'(size), 128'(value));
		get_value(cmd_get_valid, 1'b0, value);
		check_value("core data_valid", 128'(0), 128'(value));
		get_value(cmd_get_width, 1'b1, value);
		check_value("mem width", 128'(100), 128'(value));
		get_value(cmd_get_depth, 1'b1, value);
		check_value("mem depth", 128'(size), 128'(value));
		get_value(cmd_get_valid, 1'b1, value);
		check_value("mem data_valid", 128'(0), 128'(value));
	endtask

	task automatic capture_core_window();
		probe_core_t expected [8];
		logic [63:0] value;
		int j;
		send_cmd(cmd_set_duration, 1'b0, 32'd7);
		send_cmd(cmd_set_delay, 1'b0, 32'd0);
		fill_stimulus(12);
		for (j = 0; j < 8; j++) begin
			expected[j] = core_stim[j + 1];
		end
		drive_capture(1'b1, 1'b0, 12);
		wait_valid(1'b0);
		send_cmd(cmd_get_data, 1'b0, 32'd0);
		for (j = 0; j < 8; j++) begin
			read_core_sample(expected[j], j);
		end
		get_value(cmd_get_valid, 1'b0, value);
		check_value("core data_valid after readout", 128'(0), 128'(value));
	endtask

	task automatic capture_mem_delayed();
		probe_mem_t expected [4];
		logic [63:0] value;
		int j;
		send_cmd(cmd_set_delay, 1'b1, 32'd5);
		send_cmd(cmd_set_duration, 1'b1, 32'd3);
		fill_stimulus(12);
		for (j = 0; j < 4; j++) begin
			expected[j] = mem_stim[j + 6];  // Delay of 5 pushes the first sample to t+6.
		end
		drive_capture(1'b0, 1'b1, 12);
		wait_valid(1'b1);
		send_cmd(cmd_get_data, 1'b1, 32'd0);
		for (j = 0; j < 4; j++) begin
			read_mem_sample(expected[j], j);
		end
		get_value(cmd_get_valid, 1'b1, value);
		check_value("mem data_valid after readout", 128'(0), 128'(value));
	endtask

	task automatic capture_both_channels();
		probe_core_t core_exp [6];
		probe_mem_t mem_exp [3];
		logic [63:0] value;
		int j;
		send_cmd(cmd_set_duration, 1'b0, 32'd5);
		get_value(cmd_get_depth, 1'b1, value);
		check_value("mem depth after core set", 128'(4), 128'(value));
		send_cmd(cmd_set_duration, 1'b1, 32'd2);
		send_cmd(cmd_set_delay, 1'b1, 32'd2);
		get_value(cmd_get_depth, 1'b0, value);
		check_value("core depth after mem set", 128'(6), 128'(value));
		fill_stimulus(12);
		for (j = 0; j < 6; j++) begin
			core_exp[j] = core_stim[j + 1];
		end
		for (j = 0; j < 3; j++) begin
			mem_exp[j] = mem_stim[j + 3];
		end
		drive_capture(1'b1, 1'b1, 12);
		wait_valid(1'b0);
		wait_valid(1'b1);
		for (j = 0; j < 6; j++) begin
			send_cmd(cmd_get_data, 1'b0, 32'd0);
			read_core_sample(core_exp[j], j);
			if (j < 3) begin
				send_cmd(cmd_get_data, 1'b1, 32'd0);
				read_mem_sample(mem_exp[j], j);
			end
		end
		get_value(cmd_get_valid, 1'b0, value);
		check_value("core data_valid after interleave", 128'(0), 128'(value));
		get_value(cmd_get_valid, 1'b1, value);
		check_value("mem data_valid after interleave", 128'(0), 128'(value));
	endtask

	task automatic ignore_stray_reads();
		probe_core_t expected [4];
		logic [63:0] value;
		int j;
		send_cmd(cmd_set_duration, 1'b0, 32'd3);
		send_cmd(cmd_set_delay, 1'b0, 32'd8);
		fill_stimulus(16);
		for (j = 0; j < 4; j++) begin
			expected[j] = core_stim[j + 9];  // Delay of 8 pushes the first sample to t+9.
		end
		fork
			drive_capture(1'b1, 1'b0, 16);
			begin
				send_cmd(cmd_get_data, 1'b0, 32'd0);
				repeat (3) pulse_read();  // Still in the delay, so data_valid is low.
			end
		join
		wait_valid(1'b0);
		repeat (3) pulse_read();
		send_cmd(cmd_get_depth, 1'b0, 32'd0);
		repeat (2) pulse_read();
		send_cmd(cmd_get_data, 1'b0, 32'd0);
		for (j = 0; j < 4; j++) begin
			read_core_sample(expected[j], j);
		end
		get_value(cmd_get_valid, 1'b0, value);
		check_value("core data_valid after stray reads", 128'(0), 128'(value));
	endtask

	initial begin
		seed = 30;
		errors = 0;
		reset = 1'b1;
		start_core = 1'b0;
		start_mem = 1'b0;
		core_probe = '0;
		mem_probe = '0;
		bus_in = '0;
		bus_write = 1'b0;
		bus_read = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		check_reset_values();
		capture_core_window();
		capture_mem_delayed();
		capture_both_channels();
		ignore_stray_reads();

		@(posedge clk);
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- verif/scope_properties.sv
module scope_properties #(
	parameter int AW = 4
) (
	input logic clk,
	input logic reset,
	input logic waiting,
	input logic recording,
	input logic data_valid,
	input logic [AW-1:0] waddr,
	input logic [AW-1:0] waddr_end
);

	// The delay phase hands over to recording without any overlap.
	wait_or_record: assert property (@(posedge clk) disable iff (reset)
		!(waiting && recording))
		else $error("Capture channel is waiting and recording at once");

	valid_after_record: assert property (@(posedge clk) disable iff (reset)
		recording |-> !data_valid)
		else $error("Capture channel shows valid data while still recording");

	write_in_window: assert property (@(posedge clk) disable iff (reset)
		recording |-> (waddr <= waddr_end))
		else $error("Write pointer moved past the programmed end address");

endmodule

bind scope_capture scope_properties #(
	.AW(aw)
) u_props (
	.clk(clk),
	.reset(reset),
	.waiting(waiting),
	.recording(recording),
	.data_valid(data_valid),
	.waddr(waddr),
	.waddr_end(waddr_end)
);

//--- rtl/scope_top.sv
module scope_top #(
	parameter int SIZE = 64
) (
	input logic clk,
	input logic reset,
	input logic start_core,
	input logic start_mem,
	input scope_pkg::probe_core_t core_probe,
	input scope_pkg::probe_mem_t mem_probe,
	input scope_pkg::scope_cmd_t bus_in,
	input logic bus_write,
	input logic bus_read,
	output logic [scope_pkg::scope_busw-1:0] bus_out
);
	import scope_pkg::*;

	scope_ctrl_t core_ctrl;
	scope_ctrl_t mem_ctrl;
	scope_status_t core_status;
	scope_status_t mem_status;

	// Pipeline status probe, one word per sample.
	scope_capture #(
		.SIZE(SIZE),
		.sample_t(probe_core_t)
	) u_core_capture (
		.clk(clk),
		.reset(reset),
		.start(start_core),
		.sample(core_probe),
		.ctrl(core_ctrl),
		.status(core_status)
	);

	// Memory request probe, two words per sample.
	scope_capture #(
		.SIZE(SIZE),
		.sample_t(probe_mem_t)
	) u_mem_capture (
		.clk(clk),
		.reset(reset),
		.start(start_mem),
		.sample(mem_probe),
		.ctrl(mem_ctrl),
		.status(mem_status)
	);

	scope_bus_port #(
		.CORE_WIDTH($bits(probe_core_t)),
		.MEM_WIDTH($bits(probe_mem_t))
	) u_bus_port (
		.clk(clk),
		.reset(reset),
		.bus_in(bus_in),
		.bus_write(bus_write),
		.bus_read(bus_read),
		.bus_out(bus_out),
		.core_ctrl(core_ctrl),
		.mem_ctrl(mem_ctrl),
		.core_status(core_status),
		.mem_status(mem_status)
	);

endmodule

//--- rtl/scope_bus_port.sv
module scope_bus_port #(
	parameter int CORE_WIDTH = 40,
	parameter int MEM_WIDTH = 100
) (
	input logic clk,
	input logic reset,
	input scope_pkg::scope_cmd_t bus_in,
	input logic bus_write,
	input logic bus_read,
	output logic [scope_pkg::scope_busw-1:0] bus_out,
	output scope_pkg::scope_ctrl_t core_ctrl,
	output scope_pkg::scope_ctrl_t mem_ctrl,
	input scope_pkg::scope_status_t core_status,
	input scope_pkg::scope_status_t mem_status
);
	import scope_pkg::*;

	scope_get_e sel;
	logic sel_chan;
	logic is_get;
	logic set_delay;
	logic set_duration;
	logic rd_data;
	scope_status_t st;
	logic [31:0] chan_width;

	// Command decode.
	always_comb begin
		is_get = 1'b0;
		set_delay = 1'b0;
		set_duration = 1'b0;
		if (bus_write) begin
			case (bus_in.code)
				cmd_get_valid,
				cmd_get_data,
				cmd_get_width,
				cmd_get_depth: is_get = 1'b1;
				cmd_set_delay: set_delay = 1'b1;
				cmd_set_duration: set_duration = 1'b1;
				default: ;                           // Reserved codes are ignored.
			endcase
		end
	end

	// Read select and channel hold until the next get.
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= get_valid;
			sel_chan <= 1'b0;
		end else if (is_get) begin
			sel <= scope_get_e'(bus_in.code[1:0]);  // Get codes map onto read selects.
			sel_chan <= bus_in.chan;
		end
	end

	assign rd_data = bus_read && (sel == get_data);

	assign core_ctrl = '{
		set_delay: set_delay && !bus_in.chan,
		set_duration: set_duration && !bus_in.chan,
		value: bus_in.arg[31:0],
		rd_next: rd_data && !sel_chan
	};

	assign mem_ctrl = '{
		set_delay: set_delay && bus_in.chan,
		set_duration: set_duration && bus_in.chan,
		value: bus_in.arg[31:0],
		rd_next: rd_data && sel_chan
	};

	// Read data from the latched selection.
	always_comb begin
		st = sel_chan ? mem_status : core_status;
		chan_width = sel_chan ? 32'(MEM_WIDTH) : 32'(CORE_WIDTH);
		case (sel)
			get_valid: bus_out = scope_busw'(st.data_valid);
			get_data: bus_out = st.rd_word;
			get_width: bus_out = scope_busw'(chan_width);
			default: bus_out = scope_busw'(st.depth);
		endcase
	end

endmodule

//--- rtl/scope_capture.sv
module scope_capture #(
	parameter int SIZE = 64,
	parameter type sample_t = logic [scope_pkg::scope_busw-1:0]
) (
	input logic clk,
	input logic reset,
	input logic start,
	input sample_t sample,
	input scope_pkg::scope_ctrl_t ctrl,
	output scope_pkg::scope_status_t status
);
	import scope_pkg::*;

	localparam int width = $bits(sample_t);
	localparam int words = (width + scope_busw - 1) / scope_busw;
	localparam int aw = (SIZE > 1) ? $clog2(SIZE) : 1;
	localparam int ow = (words > 1) ? $clog2(words) : 1;

	sample_t mem [SIZE];

	logic [aw-1:0] waddr;
	logic [aw-1:0] raddr;
	logic [aw-1:0] waddr_end;
	logic [ow-1:0] rd_off;
	logic [31:0] delay_val;
	logic [31:0] delay_cntr;
	logic waiting;
	logic recording;
	logic data_valid;
	logic wr_en;
	logic wr_last;
	logic last_word;
	logic [words*scope_busw-1:0] rd_line;

	assign wr_en = recording && !start;              // A new start wins over an old capture.
	assign wr_last = wr_en && (waddr == waddr_end);
	assign last_word = (rd_off == ow'(words - 1));

	// Programmed delay and end address.
	always_ff @(posedge clk) begin
		if (reset) begin
			delay_val <= '0;
			waddr_end <= aw'(SIZE - 1);
		end else begin
			if (ctrl.set_delay) begin
				delay_val <= ctrl.value;
			end
			if (ctrl.set_duration) begin
				waddr_end <= ctrl.value[aw-1:0];     // Value is depth minus one.
			end
		end
	end

	// Delay countdown, then recording until the end address.
	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
			recording <= 1'b0;
			delay_cntr <= '0;
			waddr <= '0;
		end else if (start) begin
			waddr <= '0;
			delay_cntr <= delay_val;
			waiting <= (delay_val != '0);
			recording <= (delay_val == '0);
		end else if (waiting) begin
			delay_cntr <= delay_cntr - 32'd1;
			if (delay_cntr == 32'd1) begin
				waiting <= 1'b0;
				recording <= 1'b1;
			end
		end else if (recording) begin
			waddr <= waddr + 1'b1;
			if (waddr == waddr_end) begin
				recording <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[waddr] <= sample;
		end
	end

	// Readout walks every bus word of a sample before moving to the next.
	always_ff @(posedge clk) begin
		if (reset) begin
			data_valid <= 1'b0;
			raddr <= '0;
			rd_off <= '0;
		end else if (start) begin
			data_valid <= 1'b0;
			raddr <= '0;
			rd_off <= '0;
		end else begin
			if (wr_last) begin
				data_valid <= 1'b1;
			end
			if (ctrl.rd_next && data_valid) begin
				if (last_word) begin
					rd_off <= '0;
					raddr <= raddr + 1'b1;
					if (raddr == waddr_end) begin
						data_valid <= 1'b0;          // Final word has been read.
					end
				end else begin
					rd_off <= rd_off + 1'b1;
				end
			end
		end
	end

	// Zero pad the sample up to a whole number of bus words.
	always_comb begin
		rd_line = '0;
		rd_line[width-1:0] = mem[raddr];
	end

	always_comb begin
		status.data_valid = data_valid;
		status.depth = 32'(waddr_end) + 32'd1;
		status.rd_word = rd_line[rd_off*scope_busw +: scope_busw];  // Low word first.
	end

endmodule

//--- rtl/scope_pkg.sv
package scope_pkg;

	localparam int scope_busw = 64;

	typedef enum logic [2:0] {
		cmd_get_valid,
		cmd_get_data,
		cmd_get_width,
		cmd_get_depth,
		cmd_set_delay,
		cmd_set_duration,
		cmd_reserved1,
		cmd_reserved2
	} scope_cmd_e;

	typedef enum logic [1:0] {
		get_valid,
		get_data,
		get_width,
		get_depth
	} scope_get_e;

	typedef struct packed {
		logic [58:0] arg;
		logic chan;          // 0 is core, 1 is memory.
		scope_cmd_e code;
		logic spare;
	} scope_cmd_t;

	typedef struct packed {
		logic set_delay;
		logic set_duration;
		logic [31:0] value;
		logic rd_next;
	} scope_ctrl_t;

	typedef struct packed {
		logic data_valid;
		logic [31:0] depth;  // Programmed sample count.
		logic [scope_busw-1:0] rd_word;
	} scope_status_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0] warp_id;
		logic stall;
		logic issue;
		logic [1:0] stage;
	} probe_core_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [63:0] wdata;
		logic rw;
		logic req_valid;
		logic [1:0] tag;
	} probe_mem_t;

endpackage
